/* buffer_pkg.sv */
/*
  Byte buffer datapath definitions
  Byte width and the stream beat that the buffer ports carry
*/
`default_nettype none

package buffer_pkg;

  // ------------------------------
  // Datapath width
  // ------------------------------

  // One byte per beat, same as the RAM word
  localparam int data_w = 8;

  // ------------------------------
  // Stream beat
  // ------------------------------

  // Valid qualifies data, and ready travels as its own wire
  // Data holds while valid is high until the beat transfers
  typedef struct packed {
    logic              valid;
    logic [data_w-1:0] data;
  } stream_t;

  // Level width is ADDR_W + 1 so that a completely full buffer can be told
  // apart from an empty one. It depends on the module parameter and is
  // derived in each module.

endpackage

`default_nettype wire

/* csr_pkg.sv */
/*
  Register block definitions
  AXI4-Lite request and response bundles, response codes,
  register word indexes and the control word sent to the buffer
*/
`default_nettype none

package csr_pkg;

  // ------------------------------
  // AXI4-Lite bus
  // ------------------------------

  localparam int axil_addr_w = 4;
  localparam int axil_data_w = 32;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } resp_e;

  // Master to slave
  typedef struct packed {
    logic                   aw_valid;
    logic [axil_addr_w-1:0] aw_addr;
    logic                   w_valid;
    logic [axil_data_w-1:0] w_data;
    logic                   b_ready;
    logic                   ar_valid;
    logic [axil_addr_w-1:0] ar_addr;
    logic                   r_ready;
  } axil_req_t;

  // Slave to master
  typedef struct packed {
    logic                   aw_ready;
    logic                   w_ready;
    logic                   b_valid;
    resp_e                  b_resp;
    logic                   ar_ready;
    logic                   r_valid;
    logic [axil_data_w-1:0] r_data;
    resp_e                  r_resp;
  } axil_rsp_t;

  // Handshake phases, one FSM for writes and one for reads
  typedef enum logic [1:0] {
    AXIL_IDLE,
    AXIL_ACCEPT,
    AXIL_RESP
  } axil_state_e;

  // ------------------------------
  // Register map
  // ------------------------------

  // Word index, taken from address bits 3:2
  typedef enum logic [1:0] {
    REG_CTRL   = 2'd0,
    REG_THRESH = 2'd1,
    REG_STATUS = 2'd2
  } reg_e;

  // Flush is a single-cycle pulse
  typedef struct packed {
    logic enable;
    logic flush;
    logic irq_en;
  } ctrl_t;

endpackage

`default_nettype wire

/* dpram_1024x8.sv */
/*
  Dual-port byte RAM
  One synchronous write port and one registered read port,
  both on rclk. Read data changes only when ren is high.
*/
`default_nettype none

module dpram_1024x8 #(
  parameter int ADDR_W = 10
) (
  input  logic                          rclk,
  input  logic                          wen,
  input  logic [ADDR_W-1:0]             waddr,
  input  logic [buffer_pkg::data_w-1:0] wdata,
  input  logic                          ren,
  input  logic [ADDR_W-1:0]             raddr,
  output logic [buffer_pkg::data_w-1:0] rdata
);

  localparam int DEPTH = 1 << ADDR_W;

  // Storage array
  logic [buffer_pkg::data_w-1:0] mem [0:DEPTH-1];

  // ------------------------------
  // Write port
  // ------------------------------
  always_ff @(posedge rclk) begin
    if (wen) begin
      mem[waddr] <= wdata;
    end
  end

  // ------------------------------
  // Read port
  // ------------------------------

  // Output register keeps its word between reads, so the
  // controller can park a fetched byte here
  always_ff @(posedge rclk) begin
    if (ren) begin
      rdata <= mem[raddr];
    end
  end

endmodule

`default_nettype wire

/* stream_fifo_ctrl.sv */
/*
  Stream buffer controller
  Write and read pointers, fill level, RAM prefetch and the
  output holding stage. Flush clears all of it in one cycle.
*/
`default_nettype none

module stream_fifo_ctrl #(
  parameter int ADDR_W = 10
) (
  input  logic                          rclk,
  input  logic                          arst_n,
  input  csr_pkg::ctrl_t                ctrl,
  input  buffer_pkg::stream_t           s_in,
  output logic                          s_ready,
  output buffer_pkg::stream_t           m_out,
  input  logic                          m_ready,
  output logic [ADDR_W:0]               level,
  output logic                          ram_wen,
  output logic [ADDR_W-1:0]             ram_waddr,
  output logic [buffer_pkg::data_w-1:0] ram_wdata,
  output logic                          ram_ren,
  output logic [ADDR_W-1:0]             ram_raddr,
  input  logic [buffer_pkg::data_w-1:0] ram_rdata
);

  localparam int LVL_W = ADDR_W + 1;
  localparam logic [LVL_W-1:0] DEPTH = {1'b1, {ADDR_W{1'b0}}};

  // EMPTY  nothing held, RAM read register free
  // FETCH  nothing held, fetched byte sits in the RAM read register
  // HOLD   byte held on m_out, pf_valid marks a second byte waiting
  typedef enum logic [1:0] {
    OUT_EMPTY,
    OUT_FETCH,
    OUT_HOLD
  } out_state_e;

  // Pointers carry one extra bit so that unread = wr_ptr - rd_ptr
  logic [LVL_W-1:0]              wr_ptr;
  logic [LVL_W-1:0]              rd_ptr;
  logic [LVL_W-1:0]              unread;
  out_state_e                    out_state;
  out_state_e                    out_state_nxt;
  logic                          pf_valid;
  logic                          pf_valid_nxt;
  logic [buffer_pkg::data_w-1:0] out_data;
  logic                          wr_fire;
  logic                          rd_fire;
  logic                          rdreg_full;
  logic                          load;

  // ------------------------------
  // Handshakes
  // ------------------------------

  // Hold input off during a flush so no byte is taken and then dropped
  assign s_ready = ctrl.enable & ~ctrl.flush & (level != DEPTH);
  assign wr_fire = s_in.valid & s_ready;
  assign rd_fire = m_out.valid & m_ready;

  assign m_out.valid = (out_state == OUT_HOLD);
  assign m_out.data  = out_data;

  // ------------------------------
  // RAM access
  // ------------------------------
  assign unread     = wr_ptr - rd_ptr;
  assign rdreg_full = (out_state == OUT_FETCH) | pf_valid;

  // Move the parked byte when the stage is free or draining
  assign load = rdreg_full & ((out_state != OUT_HOLD) | m_ready);

  // New read only if the read register is free or being emptied
  assign ram_ren   = (unread != '0) & (~rdreg_full | load);
  assign ram_raddr = rd_ptr[ADDR_W-1:0];

  assign ram_wen   = wr_fire;
  assign ram_waddr = wr_ptr[ADDR_W-1:0];
  assign ram_wdata = s_in.data;

  // ------------------------------
  // Output stage next state
  // ------------------------------
  always_comb begin
    out_state_nxt = out_state;
    pf_valid_nxt  = pf_valid;
    if (load) begin
      out_state_nxt = OUT_HOLD;
      pf_valid_nxt  = ram_ren;
    end else if (out_state == OUT_HOLD) begin
      if (m_ready) begin
        // Held byte leaves with nothing parked behind it
        out_state_nxt = ram_ren ? OUT_FETCH : OUT_EMPTY;
        pf_valid_nxt  = 1'b0;
      end else begin
        pf_valid_nxt = pf_valid | ram_ren;
      end
    end else begin
      out_state_nxt = ram_ren ? OUT_FETCH : OUT_EMPTY;
      pf_valid_nxt  = 1'b0;
    end
  end

  // ------------------------------
  // Control state
  // ------------------------------
  always_ff @(posedge rclk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      level     <= '0;
      out_state <= OUT_EMPTY;
      pf_valid  <= 1'b0;
    end else if (ctrl.flush) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      level     <= '0;
      out_state <= OUT_EMPTY;
      pf_valid  <= 1'b0;
    end else begin
      if (wr_fire) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (ram_ren) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Level covers RAM, parked and held bytes
      case ({wr_fire, rd_fire})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: level <= level;
      endcase
      out_state <= out_state_nxt;
      pf_valid  <= pf_valid_nxt;
    end
  end

  // Output byte register
  always_ff @(posedge rclk) begin
    if (load) begin
      out_data <= ram_rdata;
    end
  end

endmodule

`default_nettype wire

/* buffer_csr.sv */
/*
  Buffer register block
  AXI4-Lite slave with control, threshold and status words.
  Drives the control bundle and the almost-full interrupt.
*/
`default_nettype none

module buffer_csr #(
  parameter int ADDR_W = 10
) (
  input  logic               rclk,
  input  logic               arst_n,
  input  csr_pkg::axil_req_t axil_req,
  output csr_pkg::axil_rsp_t axil_rsp,
  input  logic [ADDR_W:0]    level,
  output csr_pkg::ctrl_t     ctrl,
  output logic               irq
);

  localparam int LVL_W  = ADDR_W + 1;
  localparam int DATA_W = csr_pkg::axil_data_w;
  localparam logic [LVL_W-1:0] DEPTH = {1'b1, {ADDR_W{1'b0}}};

  // Highest legal byte address, the STATUS word
  localparam logic [csr_pkg::axil_addr_w-1:0] ADDR_MAX = 8;

  csr_pkg::axil_state_e wr_state;
  csr_pkg::axil_state_e rd_state;
  csr_pkg::ctrl_t       ctrl_q;
  logic [LVL_W-1:0]     thresh;
  csr_pkg::reg_e        wr_idx;
  csr_pkg::reg_e        rd_idx;
  logic                 wr_take;
  logic                 rd_take;
  logic                 wr_err;
  logic                 rd_err;
  csr_pkg::resp_e       b_resp_q;
  csr_pkg::resp_e       r_resp_q;
  logic [DATA_W-1:0]    r_data_q;
  logic [DATA_W-1:0]    rd_mux;
  logic [DATA_W-1:0]    status;
  logic                 empty;
  logic                 full;
  logic                 almost_full;

  // ------------------------------
  // Address decode
  // ------------------------------
  assign wr_idx = csr_pkg::reg_e'(axil_req.aw_addr[3:2]);
  assign rd_idx = csr_pkg::reg_e'(axil_req.ar_addr[3:2]);

  // STATUS is read-only
  assign wr_err = (axil_req.aw_addr > ADDR_MAX) | (wr_idx == csr_pkg::REG_STATUS);
  assign rd_err = (axil_req.ar_addr > ADDR_MAX);

  assign wr_take = (wr_state == csr_pkg::AXIL_ACCEPT) & axil_req.aw_valid & axil_req.w_valid;
  assign rd_take = (rd_state == csr_pkg::AXIL_ACCEPT) & axil_req.ar_valid;

  // ------------------------------
  // Write channel FSM
  // ------------------------------
  always_ff @(posedge rclk or negedge arst_n) begin
    if (!arst_n) begin
      wr_state <= csr_pkg::AXIL_IDLE;
    end else begin
      case (wr_state)
        csr_pkg::AXIL_IDLE: begin
          if (axil_req.aw_valid && axil_req.w_valid) begin
            wr_state <= csr_pkg::AXIL_ACCEPT;
          end
        end
        csr_pkg::AXIL_ACCEPT: begin
          wr_state <= wr_take ? csr_pkg::AXIL_RESP : csr_pkg::AXIL_IDLE;
        end
        csr_pkg::AXIL_RESP: begin
          if (axil_req.b_ready) begin
            wr_state <= csr_pkg::AXIL_IDLE;
          end
        end
        default: wr_state <= csr_pkg::AXIL_IDLE;
      endcase
    end
  end

  // ------------------------------
  // Read channel FSM
  // ------------------------------
  always_ff @(posedge rclk or negedge arst_n) begin
    if (!arst_n) begin
      rd_state <= csr_pkg::AXIL_IDLE;
    end else begin
      case (rd_state)
        csr_pkg::AXIL_IDLE: begin
          if (axil_req.ar_valid) begin
            rd_state <= csr_pkg::AXIL_ACCEPT;
          end
        end
        csr_pkg::AXIL_ACCEPT: begin
          rd_state <= rd_take ? csr_pkg::AXIL_RESP : csr_pkg::AXIL_IDLE;
        end
        csr_pkg::AXIL_RESP: begin
          if (axil_req.r_ready) begin
            rd_state <= csr_pkg::AXIL_IDLE;
          end
        end
        default: rd_state <= csr_pkg::AXIL_IDLE;
      endcase
    end
  end

  // ------------------------------
  // Control and threshold
  // ------------------------------

  // Threshold resets above depth so almost_full starts low
  always_ff @(posedge rclk or negedge arst_n) begin
    if (!arst_n) begin
      ctrl_q <= '0;
      thresh <= '1;
    end else begin
      ctrl_q.flush <= 1'b0;
      if (wr_take && !wr_err) begin
        case (wr_idx)
          csr_pkg::REG_CTRL: begin
            ctrl_q.enable <= axil_req.w_data[0];
            ctrl_q.flush  <= axil_req.w_data[1];
            ctrl_q.irq_en <= axil_req.w_data[2];
          end
          csr_pkg::REG_THRESH: thresh <= axil_req.w_data[LVL_W-1:0];
          default: ;
        endcase
      end
    end
  end

  assign ctrl = ctrl_q;

  // ------------------------------
  // Status and readback
  // ------------------------------
  assign empty       = (level == '0);
  assign full        = (level == DEPTH);
  assign almost_full = (level >= thresh);

  always_comb begin
    status             = '0;
    status[LVL_W-1:0]  = level;
    status[16]         = empty;
    status[17]         = full;
    status[18]         = almost_full;
  end

  // Flush always reads back as 0
  always_comb begin
    case (rd_idx)
      csr_pkg::REG_CTRL:   rd_mux = {29'b0, ctrl_q.irq_en, 1'b0, ctrl_q.enable};
      csr_pkg::REG_THRESH: rd_mux = DATA_W'(thresh);
      csr_pkg::REG_STATUS: rd_mux = status;
      default:             rd_mux = '0;
    endcase
  end

  // Response payload
  always_ff @(posedge rclk) begin
    if (wr_take) begin
      b_resp_q <= wr_err ? csr_pkg::SLVERR : csr_pkg::OKAY;
    end
    if (rd_take) begin
      r_resp_q <= rd_err ? csr_pkg::SLVERR : csr_pkg::OKAY;
      r_data_q <= rd_err ? '0 : rd_mux;
    end
  end

  always_comb begin
    axil_rsp          = '0;
    axil_rsp.aw_ready = (wr_state == csr_pkg::AXIL_ACCEPT);
    axil_rsp.w_ready  = (wr_state == csr_pkg::AXIL_ACCEPT);
    axil_rsp.b_valid  = (wr_state == csr_pkg::AXIL_RESP);
    axil_rsp.b_resp   = b_resp_q;
    axil_rsp.ar_ready = (rd_state == csr_pkg::AXIL_ACCEPT);
    axil_rsp.r_valid  = (rd_state == csr_pkg::AXIL_RESP);
    axil_rsp.r_data   = r_data_q;
    axil_rsp.r_resp   = r_resp_q;
  end

  // ------------------------------
  // Interrupt
  // ------------------------------
  always_ff @(posedge rclk or negedge arst_n) begin
    if (!arst_n) begin
      irq <= 1'b0;
    end else begin
      irq <= ctrl_q.irq_en & almost_full;
    end
  end

endmodule

`default_nettype wire

/* byte_buffer_top.sv */
/*
  Byte stream buffer top level
  Dual-port RAM, stream controller and AXI4-Lite register block
*/
`default_nettype none

module byte_buffer_top #(
  parameter int ADDR_W = 10
) (
  input  logic                rclk,
  input  logic                arst_n,
  input  buffer_pkg::stream_t s_in,
  output logic                s_ready,
  output buffer_pkg::stream_t m_out,
  input  logic                m_ready,
  input  csr_pkg::axil_req_t  axil_req,
  output csr_pkg::axil_rsp_t  axil_rsp,
  output logic                irq
);

  // Controller to RAM
  logic                          ram_wen;
  logic [ADDR_W-1:0]             ram_waddr;
  logic [buffer_pkg::data_w-1:0] ram_wdata;
  logic                          ram_ren;
  logic [ADDR_W-1:0]             ram_raddr;
  logic [buffer_pkg::data_w-1:0] ram_rdata;

  // Between controller and register block
  csr_pkg::ctrl_t                ctrl;
  logic [ADDR_W:0]               level;

  dpram_1024x8 #(
    .ADDR_W (ADDR_W)
  ) dpram_inst (
    .rclk  (rclk),
    .wen   (ram_wen),
    .waddr (ram_waddr),
    .wdata (ram_wdata),
    .ren   (ram_ren),
    .raddr (ram_raddr),
    .rdata (ram_rdata)
  );

  stream_fifo_ctrl #(
    .ADDR_W (ADDR_W)
  ) fifo_ctrl_inst (
    .rclk      (rclk),
    .arst_n    (arst_n),
    .ctrl      (ctrl),
    .s_in      (s_in),
    .s_ready   (s_ready),
    .m_out     (m_out),
    .m_ready   (m_ready),
    .level     (level),
    .ram_wen   (ram_wen),
    .ram_waddr (ram_waddr),
    .ram_wdata (ram_wdata),
    .ram_ren   (ram_ren),
    .ram_raddr (ram_raddr),
    .ram_rdata (ram_rdata)
  );

  buffer_csr #(
    .ADDR_W (ADDR_W)
  ) csr_inst (
    .rclk     (rclk),
    .arst_n   (arst_n),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .level    (level),
    .ctrl     (ctrl),
    .irq      (irq)
  );

endmodule

`default_nettype wire

/* byte_buffer_sva.sv */
/*
  Byte buffer assertions
  Stream and AXI4-Lite protocol properties, bound to the top level
*/
`default_nettype none

module byte_buffer_sva #(
  parameter int ADDR_W = 10
) (
  input logic                rclk,
  input logic                arst_n,
  input buffer_pkg::stream_t s_in,
  input logic                s_ready,
  input buffer_pkg::stream_t m_out,
  input logic                m_ready,
  input csr_pkg::axil_req_t  axil_req,
  input csr_pkg::axil_rsp_t  axil_rsp,
  input csr_pkg::ctrl_t      ctrl,
  input logic [ADDR_W:0]     level
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [ADDR_W:0] DEPTH = {1'b1, {ADDR_W{1'b0}}};

  // Number of failed properties
  int unsigned fail_count = 0;

  // Bytes taken in minus bytes handed out, seen from the stream ports
  logic [ADDR_W:0] occupancy;

  always_ff @(posedge rclk or negedge arst_n) begin
    if (!arst_n) begin
      occupancy <= '0;
    end else if (ctrl.flush) begin
      occupancy <= '0;
    end else begin
      occupancy <= occupancy + (s_in.valid & s_ready) - (m_out.valid & m_ready);
    end
  end

  // ------------------------------
  // Stream side
  // ------------------------------
  a_full_blocks: assert property (@(posedge rclk) disable iff (!arst_n)
    (occupancy == DEPTH) |-> !s_ready)
    else begin
      fail_count++;
      $error("s_ready high while the buffer is full");
    end

  a_level_range: assert property (@(posedge rclk) disable iff (!arst_n)
    level <= DEPTH)
    else begin
      fail_count++;
      $error("Level above buffer depth");
    end

  // Held byte stays put under back-pressure unless a flush drops it
  a_out_stable: assert property (@(posedge rclk) disable iff (!arst_n)
    m_out.valid && !m_ready && !ctrl.flush |=> m_out.valid && $stable(m_out.data))
    else begin
      fail_count++;
      $error("Output byte changed while stalled");
    end

  // ------------------------------
  // Register block
  // ------------------------------
  a_b_hold: assert property (@(posedge rclk) disable iff (!arst_n)
    axil_rsp.b_valid && !axil_req.b_ready |=> axil_rsp.b_valid && $stable(axil_rsp.b_resp))
    else begin
      fail_count++;
      $error("Write response dropped before b_ready");
    end

  a_r_hold: assert property (@(posedge rclk) disable iff (!arst_n)
    axil_rsp.r_valid && !axil_req.r_ready |=> axil_rsp.r_valid && $stable(axil_rsp.r_data))
    else begin
      fail_count++;
      $error("Read response dropped before r_ready");
    end

endmodule

bind byte_buffer_top byte_buffer_sva #(
  .ADDR_W (ADDR_W)
) sva_inst (
  .rclk     (rclk),
  .arst_n   (arst_n),
  .s_in     (s_in),
  .s_ready  (s_ready),
  .m_out    (m_out),
  .m_ready  (m_ready),
  .axil_req (axil_req),
  .axil_rsp (axil_rsp),
  .ctrl     (ctrl),
  .level    (level)
);

`default_nettype wire

/* byte_buffer_tb.sv */
/*
  Byte buffer testbench
  Random stream traffic against a reference queue, register
  accesses over AXI4-Lite and interrupt tracking
*/
`default_nettype none

module byte_buffer_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int ADDR_W       = 10;
  localparam int DEPTH        = 1 << ADDR_W;
  localparam int THRESH_RESET = (1 << (ADDR_W + 1)) - 1;
  localparam int MAX_CYCLES   = 20000;

  localparam logic [3:0] ADDR_CTRL   = 4'h0;
  localparam logic [3:0] ADDR_THRESH = 4'h4;
  localparam logic [3:0] ADDR_STATUS = 4'h8;
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  logic                rclk;
  logic                arst_n;
  buffer_pkg::stream_t s_in;
  logic                s_ready;
  buffer_pkg::stream_t m_out;
  logic                m_ready;
  csr_pkg::axil_req_t  axil_req;
  csr_pkg::axil_rsp_t  axil_rsp;
  logic                irq;

  // Reference model state
  logic [15:0] lfsr_state;
  logic [7:0]  ref_q [$];
  logic [7:0]  exp_byte;
  logic        in_fire;
  logic        irq_chk;
  int          irq_en_ref;
  int          thresh_ref;
  int          prev_count;
  int          err_count = 0;
  int          cycle_count = 0;
  string       test_name;

  byte_buffer_top #(
    .ADDR_W (ADDR_W)
  ) byte_buffer_top_inst (
    .rclk     (rclk),
    .arst_n   (arst_n),
    .s_in     (s_in),
    .s_ready  (s_ready),
    .m_out    (m_out),
    .m_ready  (m_ready),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .irq      (irq)
  );

  always #10 rclk = ~rclk;

  // ------------------------------
  // Helpers
  // ------------------------------

  // Galois LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic lfsr_bit();
    logic out_bit;
    out_bit = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out_bit) begin
      lfsr_state = lfsr_state ^ 16'hB400;
    end
    return out_bit;
  endfunction

  function automatic logic [7:0] rand_bits(input int n);
    logic [7:0] v;
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
      v = {v[6:0], lfsr_bit()};
    end
    return v;
  endfunction

  // STATUS word as the register map defines it
  function automatic logic [31:0] status_word(input int count, input int thr);
    logic [31:0] w;
    w = 32'(count) & 32'h0000_07FF;
    w[16] = (count == 0);
    w[17] = (count == DEPTH);
    w[18] = (count >= thr);
    return w;
  endfunction

  task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      err_count++;
      $display("ERR %s: %s expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  // One stream cycle with valid and ready chances in quarters
  task automatic drive_cycle(input int v_q, input int r_q);
    @(posedge rclk);
    #2;
    if (!s_in.valid || in_fire) begin
      s_in.valid = (rand_bits(2) < v_q);
      if (s_in.valid) begin
        s_in.data = rand_bits(8);
      end
    end
    m_ready = (rand_bits(2) < r_q);
  endtask

  task automatic quiesce();
    do begin
      drive_cycle(0, 0);
    end while (s_in.valid);
  endtask

  task automatic drain(input int r_q);
    while (ref_q.size() != 0 || s_in.valid) begin
      drive_cycle(0, r_q);
    end
  endtask

  // ------------------------------
  // AXI4-Lite master
  // ------------------------------
  task automatic reg_write(input logic [3:0] addr, input logic [31:0] data,
                           input logic [1:0] exp_resp);
    logic [1:0] resp;
    @(posedge rclk);
    #2;
    axil_req.aw_valid = 1'b1;
    axil_req.aw_addr  = addr;
    axil_req.w_valid  = 1'b1;
    axil_req.w_data   = data;
    do @(negedge rclk); while (!axil_rsp.aw_ready);
    check_eq("w_ready", 1, axil_rsp.w_ready);
    @(posedge rclk);
    #2;
    axil_req.aw_valid = 1'b0;
    axil_req.w_valid  = 1'b0;
    do @(negedge rclk); while (!axil_rsp.b_valid);
    resp = axil_rsp.b_resp;
    // Response waits one edge with b_ready low
    @(posedge rclk);
    #2;
    axil_req.b_ready = 1'b1;
    @(posedge rclk);
    #2;
    axil_req.b_ready = 1'b0;
    check_eq("b_resp", exp_resp, resp);
  endtask

  task automatic reg_read_check(input string what, input logic [3:0] addr,
                                input logic [31:0] exp_data, input logic [1:0] exp_resp);
    logic [31:0] data;
    logic [1:0]  resp;
    @(posedge rclk);
    #2;
    axil_req.ar_valid = 1'b1;
    axil_req.ar_addr  = addr;
    do @(negedge rclk); while (!axil_rsp.ar_ready);
    @(posedge rclk);
    #2;
    axil_req.ar_valid = 1'b0;
    do @(negedge rclk); while (!axil_rsp.r_valid);
    data = axil_rsp.r_data;
    resp = axil_rsp.r_resp;
    // Read data waits one edge with r_ready low
    @(posedge rclk);
    #2;
    axil_req.r_ready = 1'b1;
    @(posedge rclk);
    #2;
    axil_req.r_ready = 1'b0;
    check_eq({what, " data"}, exp_data, data);
    check_eq({what, " resp"}, exp_resp, resp);
  endtask

  // ------------------------------
  // Monitor
  // ------------------------------

  // Inputs settle 2 ns after the edge, so the negedge shows what the next edge takes
  always @(negedge rclk) begin
    in_fire = 1'b0;
    if (arst_n) begin
      if (irq_chk) begin
        check_eq("irq", (irq_en_ref != 0) && (prev_count >= thresh_ref), irq);
      end
      prev_count = ref_q.size();
      if (ref_q.size() == DEPTH) begin
        check_eq("s_ready when full", 0, s_ready);
      end
      in_fire = s_in.valid & s_ready;
      if (m_out.valid && m_ready) begin
        if (ref_q.size() == 0) begin
          err_count++;
          $display("Output byte %h in test %s with nothing queued", m_out.data, test_name);
        end else begin
          exp_byte = ref_q.pop_front();
          check_eq("m_out data", exp_byte, m_out.data);
        end
      end
      if (in_fire) begin
        ref_q.push_back(s_in.data);
      end
    end
  end

  always @(posedge rclk) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles in test %s", cycle_count, test_name);
      $display("Simulation failed");
      $finish;
    end
  end

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin
    rclk       = 1'b0;
    arst_n     = 1'b0;
    s_in       = '0;
    m_ready    = 1'b0;
    axil_req   = '0;
    lfsr_state = 16'd18705;
    in_fire    = 1'b0;
    irq_chk    = 1'b0;
    irq_en_ref = 0;
    thresh_ref = THRESH_RESET;
    prev_count = 0;
    test_name  = "reset";
    repeat (16) @(posedge rclk);
    #2;
    arst_n = 1'b1;

    test_name = "idle_disabled";
    @(posedge rclk);
    #2;
    s_in.valid = 1'b1;
    s_in.data  = rand_bits(8);
    m_ready    = 1'b1;
    repeat (20) begin
      @(negedge rclk);
      check_eq("s_ready", 0, s_ready);
      check_eq("m_out valid", 0, m_out.valid);
      check_eq("irq", 0, irq);
    end
    reg_read_check("ctrl", ADDR_CTRL, 0, RESP_OKAY);
    reg_read_check("thresh", ADDR_THRESH, THRESH_RESET, RESP_OKAY);
    reg_read_check("status", ADDR_STATUS, status_word(0, thresh_ref), RESP_OKAY);

    test_name = "fill";
    reg_write(ADDR_CTRL, 32'h1, RESP_OKAY);
    while (ref_q.size() < DEPTH) begin
      drive_cycle(4, 0);
    end
    repeat (10) drive_cycle(4, 0);
    reg_read_check("status full", ADDR_STATUS, status_word(DEPTH, thresh_ref), RESP_OKAY);
    reg_write(ADDR_THRESH, 32'd1000, RESP_OKAY);
    thresh_ref = 1000;
    reg_read_check("thresh", ADDR_THRESH, 1000, RESP_OKAY);
    reg_read_check("status af", ADDR_STATUS, status_word(DEPTH, thresh_ref), RESP_OKAY);

    test_name = "drain";
    drain(2);
    @(negedge rclk);
    check_eq("m_out valid", 0, m_out.valid);
    reg_read_check("status empty", ADDR_STATUS, status_word(0, thresh_ref), RESP_OKAY);

    // Level climbs past the threshold and then falls back
    test_name = "mixed";
    reg_write(ADDR_THRESH, 32'd40, RESP_OKAY);
    thresh_ref = 40;
    reg_write(ADDR_CTRL, 32'h5, RESP_OKAY);
    irq_en_ref = 1;
    irq_chk    = 1'b1;
    repeat (300) drive_cycle(3, 1);
    quiesce();
    reg_read_check("status up", ADDR_STATUS, status_word(ref_q.size(), thresh_ref),
                   RESP_OKAY);
    repeat (300) drive_cycle(1, 3);
    drain(3);
    irq_chk = 1'b0;
    reg_write(ADDR_CTRL, 32'h1, RESP_OKAY);
    irq_en_ref = 0;
    irq_chk    = 1'b1;
    repeat (150) drive_cycle(3, 1);
    drain(4);
    irq_chk = 1'b0;

    test_name = "flush";
    repeat (100) drive_cycle(4, 0);
    quiesce();
    reg_write(ADDR_CTRL, 32'h3, RESP_OKAY);
    ref_q.delete();
    @(negedge rclk);
    check_eq("m_out valid", 0, m_out.valid);
    reg_read_check("status", ADDR_STATUS, status_word(0, thresh_ref), RESP_OKAY);
    reg_read_check("ctrl", ADDR_CTRL, 1, RESP_OKAY);
    repeat (100) drive_cycle(2, 2);
    drain(4);

    test_name = "reg_errors";
    reg_write(ADDR_STATUS, 32'h7, RESP_SLVERR);
    reg_read_check("ctrl kept", ADDR_CTRL, 1, RESP_OKAY);
    reg_read_check("thresh kept", ADDR_THRESH, thresh_ref, RESP_OKAY);
    reg_write(4'hC, 32'h5, RESP_SLVERR);
    reg_read_check("read 0xc", 4'hC, 0, RESP_SLVERR);
    reg_read_check("read 0x9", 4'h9, 0, RESP_SLVERR);
    reg_read_check("status", ADDR_STATUS, status_word(0, thresh_ref), RESP_OKAY);
    reg_read_check("ctrl after", ADDR_CTRL, 1, RESP_OKAY);

    repeat (4) @(posedge rclk);
    $display("Done after %0d cycles, %0d check errors, %0d assertion failures",
             cycle_count, err_count, byte_buffer_top_inst.sva_inst.fail_count);
    if (err_count == 0 && byte_buffer_top_inst.sva_inst.fail_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
buffer_pkg.sv
csr_pkg.sv
dpram_1024x8.sv
stream_fifo_ctrl.sv
buffer_csr.sv
byte_buffer_top.sv
byte_buffer_sva.sv
byte_buffer_tb.sv
